// File: Bender.yml
package:
  name: cpu_ctrl

sources:
  - files:
      - src/isa_pkg.sv
      - src/ctrl_pkg.sv
      - src/op_decoder.sv
      - src/cond_eval.sv
      - src/ctrl_sequencer.sv
      - src/ctrl_word_gen.sv
      - src/cpu_ctrl.sv
  - target: test
    files:
      - bench/cpu_ctrl_sva.sv
      - bench/cpu_ctrl_tb.sv

// File: bench/cpu_ctrl_sva.sv
module cpu_ctrl_sva (
	input logic clk,
	input logic rst,
	input logic mfc,
	input ctrl_pkg::ctrl_word_t ctrl,
	input ctrl_pkg::state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	import ctrl_pkg::*;

	int fail_count = 0;

	// Quiet word during reset and on the first edge after release
	reset_quiet: assert property (@(posedge clk) !rst || $rose(rst) |-> ctrl == '0)
		else
		begin
			$error("control word not zero around reset");
			fail_count++;
		end

	read_hold: assert property (@(posedge clk) disable iff (!rst)
		ctrl.rd_mem && !mfc |=> ctrl.rd_mem)
		else
		begin
			$error("memory read strobe dropped while mfc was low");
			fail_count++;
		end

	ir_no_write: assert property (@(posedge clk) !(ctrl.ld_ir && ctrl.wr_reg))
		else
		begin
			$error("instruction load and register write in the same step");
			fail_count++;
		end

	cmp_no_write: assert property (@(posedge clk)
		state inside {cmpi1, cmpi2, cmpi3, cmpi4, cmpi5, cmpi6, cmpr1, cmpr2} |-> !ctrl.wr_reg)
		else
		begin
			$error("register write during a compare step");
			fail_count++;
		end

endmodule

bind cpu_ctrl cpu_ctrl_sva cpu_ctrl_sva_i (
	.clk (clk),
	.rst (rst),
	.mfc (mfc),
	.ctrl (ctrl),
	.state (state)
);

// File: bench/cpu_ctrl_tb.sv
module cpu_ctrl_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam time period = 20ns;
	// Longest routine, its idle cycle and two reads at full mfc delay
	localparam int worst_instr = 11 + 1 + 2 * 3;
	localparam int num_instr = 40;

	////////////////////
	// Expected words
	////////////////////
	localparam ctrl_word_t zero_w = '{sel: dst, default: 1'b0};
	localparam ctrl_word_t fetch_w = '{t_pc: 1'b1, trans_x: 1'b1, ld_mar: 1'b1, ld_buf: 1'b1,
		ld_r2: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t imm_w = '{t_pc: 1'b1, trans_x: 1'b1, ld_mar: 1'b1, ld_buf: 1'b1,
		sel: dst, default: 1'b0};
	localparam ctrl_word_t pc_inc_w = '{t_r2: 1'b1, add: 1'b1, t_mar: 1'b1, ld_pc: 1'b1,
		sel: dst, default: 1'b0};
	localparam ctrl_word_t read_w = '{t_mar: 1'b1, rd_mem: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t ir_w = '{ld_ir: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t mdr_w = '{mdr_from_x: 1'b1, ld_mdr: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t ldi5_w = '{t_mdr2x: 1'b1, trans_x: 1'b1, wr_reg: 1'b1, sel: dst,
		default: 1'b0};
	localparam ctrl_word_t ldr_w = '{sel: src, rd_reg: 1'b1, trans_x: 1'b1, wr_reg: 1'b1,
		default: 1'b0};
	localparam ctrl_word_t buf_w = '{t_mdr2x: 1'b1, ld_buf: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t src_buf_w = '{sel: src, rd_reg: 1'b1, ld_buf: 1'b1, default: 1'b0};
	localparam ctrl_word_t alu_last_w = '{sel: acc, rd_reg: 1'b1, ld_flags: 1'b1, wr_reg: 1'b1,
		default: 1'b0};
	localparam ctrl_word_t cmp_last_w = '{sel: acc, rd_reg: 1'b1, ld_flags: 1'b1, default: 1'b0};
	localparam ctrl_word_t neg_w = '{sel: acc, rd_reg: 1'b1, wr_reg: 1'b1, default: 1'b0};
	localparam ctrl_word_t jmp6_w = '{t_pc: 1'b1, add: 1'b1, ld_pc: 1'b1, sel: dst, default: 1'b0};
	localparam ctrl_word_t jr_w = '{sel: acc, rd_reg: 1'b1, trans_x: 1'b1, ld_pc: 1'b1,
		default: 1'b0};

	logic clk;
	logic rst;
	instr_t ir;
	flags_t flags;
	logic mfc;
	ctrl_word_t ctrl;

	ctrl_word_t exp_q[$];
	logic mfc_q[$];
	logic [31:0] rnd;
	int delay_sum;
	int errors;
	int test_errors;
	int tests_ok;
	int tests_bad;

	cpu_ctrl dut_i (.clk(clk), .rst(rst), .ir(ir), .flags(flags), .mfc(mfc), .ctrl(ctrl));

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial
	begin
		#((5 + num_instr * worst_instr) * period * 2);
		$display("timeout: the directed tests did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Branch rule per condition code
	function automatic logic cond_expect(input logic [3:0] cc, input flags_t f);
		case (cc)
			4'b0000: return 1'b1;
			4'b0001: return f.zero;
			4'b0010: return !f.zero;
			4'b0100: return f.carry;
			4'b0101: return !f.carry;
			4'b0110: return f.overflow;
			4'b1000: return !f.overflow;
			4'b1001: return f.sign;
			4'b1010: return !f.sign;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_ctrl(input string name, input int step, input ctrl_word_t got,
		input ctrl_word_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s step %0d ctrl %h expected %h", $time, name, step,
				got, exp);
			errors++;
		end
	endtask

	task automatic check_state_len(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch at %0t: %s took %0d cycles, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// Sequence building
	////////////////////
	task automatic push(input ctrl_word_t w);
		exp_q.push_back(w);
		mfc_q.push_back(1'b0);
	endtask

	// Read word repeats once per low mfc cycle
	task automatic push_read();
		int d;
		rnd = xorshift(rnd);
		d = rnd % 4;
		delay_sum += d;
		repeat (d)
			push(read_w);
		exp_q.push_back(read_w);
		mfc_q.push_back(1'b1);
	endtask

	task automatic start_instr();
		exp_q.delete();
		mfc_q.delete();
		delay_sum = 0;
		push(zero_w);
		push(fetch_w);
		push(pc_inc_w);
		push_read();
		push(ir_w);
	endtask

	task automatic push_operand();
		push(imm_w);
		push(pc_inc_w);
		push_read();
		push(mdr_w);
	endtask

	task automatic run_instr(input string name, input opcode_t op, input flags_t f,
		input int base_len);
		int cyc;
		int len;
		push(zero_w);
		ir = {op, 9'h0a5};
		flags = f;
		mfc = mfc_q[0];
		check_ctrl(name, 0, ctrl, exp_q[0]);
		@(negedge clk);
		cyc = 1;
		len = 0;
		while (dut_i.state != idle && cyc < 64)
		begin
			mfc = (cyc < mfc_q.size()) ? mfc_q[cyc] : 1'b0;
			if (cyc < exp_q.size())
				check_ctrl(name, cyc, ctrl, exp_q[cyc]);
			else
			begin
				$display("%s kept running past its last expected step", name);
				errors++;
			end
			len++;
			cyc++;
			@(negedge clk);
		end
		if (cyc < exp_q.size())
		begin
			$display("%s returned to idle before its last expected step", name);
			errors++;
		end
		check_state_len(name, len, base_len + delay_sum);
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors)
		begin
			$display("test %s ok", name);
			tests_ok++;
		end
		else
		begin
			$display("test %s failed with %0d errors", name, errors - test_errors);
			tests_bad++;
		end
		test_errors = errors;
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic test_reset();
		repeat (5)
		begin
			@(negedge clk);
			check_ctrl("reset", 0, ctrl, zero_w);
		end
		rst = 1'b1;
		start_instr();
		push(neg_w);
		run_instr("first neg", 7'b1101000, '0, 6);
		end_test("reset");
	endtask

	task automatic test_loads();
		start_instr();
		push_operand();
		push(ldi5_w);
		run_instr("ldi", 7'b0111000, '0, 10);
		start_instr();
		push(ldr_w);
		run_instr("ldr", 7'b0111001, '0, 6);
		start_instr();
		push(neg_w);
		run_instr("neg", 7'b1101111, '0, 6);
		end_test("loads and negate");
	endtask

	task automatic test_alu();
		for (int fn = 0; fn < 4; fn++)
		begin
			start_instr();
			push_operand();
			push(buf_w);
			push(alu_last_w);
			run_instr($sformatf("alu imm fn %0d", fn), {2'b10, 2'(fn), 3'b000}, '0, 11);
			start_instr();
			push(src_buf_w);
			push(alu_last_w);
			run_instr($sformatf("alu reg fn %0d", fn), {2'b10, 2'(fn), 3'b001}, '0, 7);
		end
		end_test("alu");
	endtask

	task automatic test_compare();
		start_instr();
		push_operand();
		push(buf_w);
		push(cmp_last_w);
		run_instr("cmp imm", 7'b1100000, '0, 11);
		start_instr();
		push(src_buf_w);
		push(cmp_last_w);
		run_instr("cmp reg", 7'b1100001, '0, 7);
		end_test("compare");
	endtask

	task automatic test_jumps();
		logic [3:0] cc;
		flags_t f;
		flags_t first_f[9];
		logic taken;
		for (int n = 0; n < 18; n++)
		begin
			// Nine codes with neither pair 11
			cc = {2'((n % 9) / 3), 2'(n % 3)};
			// Second pass inverts the flags so each code goes both ways
			if (n < 9)
			begin
				rnd = xorshift(rnd);
				f = rnd[3:0];
				first_f[n] = f;
			end
			else
				f = ~first_f[n - 9];
			taken = cond_expect(cc, f);
			start_instr();
			push_operand();
			if (taken)
			begin
				push(buf_w);
				push(jmp6_w);
			end
			run_instr($sformatf("jump cc %b flags %b", cc, f),
				{2'b01, cc[3:2], 1'b1, cc[1:0]}, f, taken ? 11 : 9);
		end
		end_test("conditional jump");
	endtask

	task automatic test_jr();
		for (int k = 0; k < 4; k++)
		begin
			start_instr();
			push(jr_w);
			run_instr($sformatf("jr %0d", k), {5'b00111, 2'(k)}, '0, 6);
		end
		end_test("jump register");
	endtask

	task automatic test_unknown();
		opcode_t ops[4];
		ops = '{7'b0000000, 7'b1111111, 7'b0100111, 7'b0100000};
		foreach (ops[k])
		begin
			start_instr();
			run_instr($sformatf("unknown %b", ops[k]), ops[k], '0, 5);
		end
		end_test("unknown opcode");
	endtask

	initial
	begin
		rst = 1'b0;
		ir = '0;
		flags = '0;
		mfc = 1'b0;
		rnd = 32'h1564;
		errors = 0;
		test_errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		test_reset();
		test_loads();
		test_alu();
		test_compare();
		test_jumps();
		test_jr();
		test_unknown();
		if (dut_i.cpu_ctrl_sva_i.fail_count != 0)
		begin
			$display("bound assertions failed %0d times", dut_i.cpu_ctrl_sva_i.fail_count);
			errors += dut_i.cpu_ctrl_sva_i.fail_count;
		end
		$display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: src.f
src/isa_pkg.sv
src/ctrl_pkg.sv
src/op_decoder.sv
src/cond_eval.sv
src/ctrl_sequencer.sv
src/ctrl_word_gen.sv
src/cpu_ctrl.sv
bench/cpu_ctrl_sva.sv
bench/cpu_ctrl_tb.sv

// File: src/cond_eval.sv
module cond_eval (
	input isa_pkg::instr_t ir,
	input isa_pkg::flags_t flags,
	output logic cond_ok
);

	import isa_pkg::*;

	cond_t cc;

	assign cc = cond_t'({ir.br.cond_hi, ir.br.cond_lo});

	always_comb
	begin
		case (cc)
			cond_al:
				cond_ok = 1'b1;
			cond_z:
				cond_ok = flags.zero;
			cond_nz:
				cond_ok = !flags.zero;
			cond_c:
				cond_ok = flags.carry;
			cond_nc:
				cond_ok = !flags.carry;
			cond_v:
				cond_ok = flags.overflow;
			cond_nv:
				cond_ok = !flags.overflow;
			cond_s:
				cond_ok = flags.sign;
			cond_ns:
				cond_ok = !flags.sign;
			// Meaningless codes never branch
			default:
				cond_ok = 1'b0;
		endcase
	end

endmodule

// File: src/cpu_ctrl.sv
module cpu_ctrl (
	input logic clk,
	input logic rst,
	input isa_pkg::instr_t ir,
	input isa_pkg::flags_t flags,
	input logic mfc,
	output ctrl_pkg::ctrl_word_t ctrl
);

	import ctrl_pkg::*;

	state_t entry;
	state_t state;
	logic cond_ok;

	op_decoder op_decoder_i (
		.ir (ir),
		.entry (entry)
	);

	cond_eval cond_eval_i (
		.ir (ir),
		.flags (flags),
		.cond_ok (cond_ok)
	);

	ctrl_sequencer ctrl_sequencer_i (
		.clk (clk),
		.rst (rst),
		.entry (entry),
		.cond_ok (cond_ok),
		.mfc (mfc),
		.state (state)
	);

	ctrl_word_gen ctrl_word_gen_i (
		.state (state),
		.ctrl (ctrl)
	);

endmodule

// File: src/ctrl_pkg.sv
package ctrl_pkg;

	////////////////////
	// Microsteps
	////////////////////

	typedef enum logic [5:0] {
		idle,
		fetch1,
		fetch2,
		fetch3,
		fetch4,
		ldi1,
		ldi2,
		ldi3,
		ldi4,
		ldi5,
		ldr1,
		alui1,
		alui2,
		alui3,
		alui4,
		alui5,
		alui6,
		alur1,
		alur2,
		cmpi1,
		cmpi2,
		cmpi3,
		cmpi4,
		cmpi5,
		cmpi6,
		cmpr1,
		cmpr2,
		neg1,
		jmp1,
		jmp2,
		jmp3,
		jmp4,
		jmp5,
		jmp6,
		jr1,
		done
	} state_t;

	////////////////////
	// Control word
	////////////////////

	// Register file read port select
	typedef enum logic [1:0] {
		dst = 2'b00,
		src = 2'b01,
		acc = 2'b10
	} reg_sel_t;

	typedef struct packed {
		// Register loads, sampled at the clock edge
		logic ld_buf;
		logic ld_flags;
		logic ld_pc;
		logic ld_r2;
		logic ld_mar;
		logic ld_mdr;
		logic ld_ir;
		// Bus drives
		logic t_pc;
		logic t_r2;
		logic t_mar;
		logic t_mdr2x;
		logic add;
		logic trans_x;
		logic rd_reg;
		logic wr_reg;
		logic rd_mem;
		logic mdr_from_x;
		reg_sel_t sel;
	} ctrl_word_t;

endpackage

// File: src/ctrl_sequencer.sv
module ctrl_sequencer (
	input logic clk,
	input logic rst,
	input ctrl_pkg::state_t entry,
	input logic cond_ok,
	input logic mfc,
	output ctrl_pkg::state_t state
);

	import ctrl_pkg::*;

	state_t next_state;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			idle: next_state = fetch1;

			////////////////////
			// Fetch
			////////////////////
			fetch1: next_state = fetch2;
			fetch2: next_state = fetch3;
			fetch3:
				if (mfc)
					next_state = fetch4;
			fetch4: next_state = entry;

			////////////////////
			// Loads and negate
			////////////////////
			ldi1: next_state = ldi2;
			ldi2: next_state = ldi3;
			ldi3:
				if (mfc)
					next_state = ldi4;
			ldi4: next_state = ldi5;
			ldi5: next_state = done;
			ldr1: next_state = done;
			neg1: next_state = done;

			////////////////////
			// ALU and compare
			////////////////////
			alui1: next_state = alui2;
			alui2: next_state = alui3;
			alui3:
				if (mfc)
					next_state = alui4;
			alui4: next_state = alui5;
			alui5: next_state = alui6;
			alui6: next_state = done;
			alur1: next_state = alur2;
			alur2: next_state = done;
			cmpi1: next_state = cmpi2;
			cmpi2: next_state = cmpi3;
			cmpi3:
				if (mfc)
					next_state = cmpi4;
			cmpi4: next_state = cmpi5;
			cmpi5: next_state = cmpi6;
			cmpi6: next_state = done;
			cmpr1: next_state = cmpr2;
			cmpr2: next_state = done;

			////////////////////
			// Jumps
			////////////////////
			jmp1: next_state = jmp2;
			jmp2: next_state = jmp3;
			jmp3:
				if (mfc)
					next_state = jmp4;
			// False condition ends the instruction here
			jmp4: next_state = cond_ok ? jmp5 : done;
			jmp5: next_state = jmp6;
			jmp6: next_state = done;
			jr1: next_state = done;

			done: next_state = idle;
			default: next_state = idle;
		endcase
	end

endmodule

// File: src/ctrl_word_gen.sv
module ctrl_word_gen (
	input ctrl_pkg::state_t state,
	output ctrl_pkg::ctrl_word_t ctrl
);

	import ctrl_pkg::*;

	always_comb
	begin
		ctrl = '0;
		ctrl.sel = dst;
		case (state)
			////////////////////
			// Fetch and operand prefix
			////////////////////

			// PC to MAR and buffer; fetch also keeps the increment in r2
			fetch1, ldi1, alui1, cmpi1, jmp1:
			begin
				ctrl.t_pc = 1'b1;
				ctrl.trans_x = 1'b1;
				ctrl.ld_mar = 1'b1;
				ctrl.ld_buf = 1'b1;
				ctrl.ld_r2 = (state == fetch1);
			end
			fetch2, ldi2, alui2, cmpi2, jmp2:
			begin
				ctrl.t_r2 = 1'b1;
				ctrl.add = 1'b1;
				ctrl.t_mar = 1'b1;
				ctrl.ld_pc = 1'b1;
			end
			// Held until mfc
			fetch3, ldi3, alui3, cmpi3, jmp3:
			begin
				ctrl.t_mar = 1'b1;
				ctrl.rd_mem = 1'b1;
			end
			fetch4:
				ctrl.ld_ir = 1'b1;
			ldi4, alui4, cmpi4, jmp4:
			begin
				ctrl.mdr_from_x = 1'b1;
				ctrl.ld_mdr = 1'b1;
			end

			////////////////////
			// Routine bodies
			////////////////////
			ldi5:
			begin
				ctrl.t_mdr2x = 1'b1;
				ctrl.trans_x = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			ldr1:
			begin
				ctrl.sel = src;
				ctrl.rd_reg = 1'b1;
				ctrl.trans_x = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			// Immediate operand into the ALU buffer
			alui5, cmpi5, jmp5:
			begin
				ctrl.t_mdr2x = 1'b1;
				ctrl.ld_buf = 1'b1;
			end
			alur1, cmpr1:
			begin
				ctrl.sel = src;
				ctrl.rd_reg = 1'b1;
				ctrl.ld_buf = 1'b1;
			end
			// Compares only touch the flags
			alui6, cmpi6, alur2, cmpr2:
			begin
				ctrl.sel = acc;
				ctrl.rd_reg = 1'b1;
				ctrl.ld_flags = 1'b1;
				ctrl.wr_reg = (state == alui6) || (state == alur2);
			end
			neg1:
			begin
				ctrl.sel = acc;
				ctrl.rd_reg = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			jmp6:
			begin
				ctrl.t_pc = 1'b1;
				ctrl.add = 1'b1;
				ctrl.ld_pc = 1'b1;
			end
			jr1:
			begin
				ctrl.sel = acc;
				ctrl.rd_reg = 1'b1;
				ctrl.trans_x = 1'b1;
				ctrl.ld_pc = 1'b1;
			end
			default:
				ctrl.sel = dst;
		endcase
	end

endmodule

// File: src/isa_pkg.sv
package isa_pkg;

	////////////////////
	// Instruction word
	////////////////////

	typedef logic [6:0] opcode_t;

	// Plain view, opcode in the top seven bits
	typedef struct packed {
		opcode_t opcode;
		logic [8:0] operand;
	} op_view_t;

	// Branch view of the same word
	typedef struct packed {
		logic [1:0] cls;
		logic [1:0] cond_hi;
		logic spare;
		logic [1:0] cond_lo;
		logic [8:0] operand;
	} br_view_t;

	typedef union packed {
		op_view_t op;
		br_view_t br;
	} instr_t;

	////////////////////
	// Opcodes
	////////////////////

	localparam opcode_t op_ldi = 7'b0111000;
	localparam opcode_t op_ldr = 7'b0111001;
	// ALU base codes, function code sits in bits 4..3
	localparam opcode_t op_alu_imm = 7'b1000000;
	localparam opcode_t op_alu_reg = 7'b1000001;
	localparam opcode_t alu_fn_mask = 7'b0011000;
	localparam opcode_t op_cmpi = 7'b1100000;
	localparam opcode_t op_cmpr = 7'b1100001;
	localparam opcode_t op_neg = 7'b1101000;
	localparam opcode_t neg_mask = 7'b0000111;
	localparam opcode_t op_jr = 7'b0011100;
	localparam opcode_t jr_mask = 7'b0000011;

	// Conditional jumps: class 01 with the spare bit set
	localparam logic [1:0] br_class = 2'b01;

	////////////////////
	// Conditions and flags
	////////////////////

	typedef enum logic [3:0] {
		cond_al = 4'b0000,
		cond_z = 4'b0001,
		cond_nz = 4'b0010,
		cond_c = 4'b0100,
		cond_nc = 4'b0101,
		cond_v = 4'b0110,
		cond_nv = 4'b1000,
		cond_s = 4'b1001,
		cond_ns = 4'b1010
	} cond_t;

	typedef struct packed {
		logic sign;
		logic overflow;
		logic zero;
		logic carry;
	} flags_t;

endpackage

// File: src/op_decoder.sv
module op_decoder (
	input isa_pkg::instr_t ir,
	output ctrl_pkg::state_t entry
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	opcode_t opcode;
	logic is_jump;

	assign opcode = ir.op.opcode;

	// Branch view: nine valid condition codes, pairs of 11 are unused
	assign is_jump = (ir.br.cls == br_class) && ir.br.spare
		&& (ir.br.cond_hi != 2'b11) && (ir.br.cond_lo != 2'b11);

	always_comb
	begin
		// Unknown opcodes fall through to done
		entry = done;
		if (opcode == op_ldi)
		begin
			entry = ldi1;
		end
		else if (opcode == op_ldr)
		begin
			entry = ldr1;
		end
		else if ((opcode & ~alu_fn_mask) == op_alu_imm)
		begin
			entry = alui1;
		end
		else if ((opcode & ~alu_fn_mask) == op_alu_reg)
		begin
			entry = alur1;
		end
		else if (opcode == op_cmpi)
		begin
			entry = cmpi1;
		end
		else if (opcode == op_cmpr)
		begin
			entry = cmpr1;
		end
		else if ((opcode & ~neg_mask) == op_neg)
		begin
			entry = neg1;
		end
		else if (is_jump)
		begin
			entry = jmp1;
		end
		else if ((opcode & ~jr_mask) == op_jr)
		begin
			entry = jr1;
		end
	end

endmodule
